/* design/cpu6502_arch_pkg.sv */
package cpu6502_arch_pkg;

    localparam int data_width = 8;   // Data bus and register width
    localparam int addr_width = 16;  // Address bus width

    typedef logic [data_width-1:0] data_t;
    typedef logic [addr_width-1:0] addr_t;

    // Start address is read from here, low byte first
    localparam addr_t reset_vector = 16'hfffc;

    // Status byte layout, bit 5 reads as one
    localparam int status_n = 7;
    localparam int status_v = 6;
    localparam int status_z = 1;
    localparam int status_c = 0;

endpackage

/* design/cpu6502_isa_pkg.sv */
package cpu6502_isa_pkg;

    // Opcode fields, aaa_bbb_cc
    typedef struct packed {
        logic [2:0] group;     // Operation within a class
        logic [2:0] mode;      // Addressing mode
        logic [1:0] op_class;  // Instruction class
    } opcode_fields_t;

    // Whole opcodes compare on raw, addressing and ALU op come from fields
    typedef union packed {
        cpu6502_arch_pkg::data_t raw;
        opcode_fields_t          fields;
    } opcode_t;

    // One-hot cycle state
    typedef struct packed {
        logic byte1;     // Opcode fetch
        logic byte2;     // Operand or dummy read
        logic byte3;     // High byte of JMP target
        logic zeropage;  // Zero-page read or write
    } cycle_t;

    localparam logic [2:0] mode_zeropage  = 3'b001;
    localparam logic [2:0] mode_immediate = 3'b010;
    localparam logic [2:0] mode_absolute  = 3'b011;

    localparam logic [1:0] class_alu = 2'b01;
    localparam logic [1:0] class_x   = 2'b10;

    localparam logic [2:0] group_store = 3'b100;  // STA STX STY
    localparam logic [2:0] group_load  = 3'b101;  // LDA LDX LDY
    localparam logic [2:0] group_cmp   = 3'b110;

    // Also forced into the opcode register at reset
    localparam cpu6502_arch_pkg::data_t opcode_jmp_abs = 8'h4c;

    // Immediate loads outside the regular mode column
    localparam cpu6502_arch_pkg::data_t opcode_ldx_imm = 8'ha2;
    localparam cpu6502_arch_pkg::data_t opcode_ldy_imm = 8'ha0;

    // Implied opcodes
    localparam cpu6502_arch_pkg::data_t opcode_tax = 8'haa;
    localparam cpu6502_arch_pkg::data_t opcode_tay = 8'ha8;
    localparam cpu6502_arch_pkg::data_t opcode_txa = 8'h8a;
    localparam cpu6502_arch_pkg::data_t opcode_tya = 8'h98;
    localparam cpu6502_arch_pkg::data_t opcode_inx = 8'he8;
    localparam cpu6502_arch_pkg::data_t opcode_iny = 8'hc8;
    localparam cpu6502_arch_pkg::data_t opcode_dex = 8'hca;
    localparam cpu6502_arch_pkg::data_t opcode_dey = 8'h88;
    localparam cpu6502_arch_pkg::data_t opcode_clc = 8'h18;
    localparam cpu6502_arch_pkg::data_t opcode_sec = 8'h38;
    localparam cpu6502_arch_pkg::data_t opcode_clv = 8'hb8;

endpackage

/* design/cpu6502_alu.sv */
`timescale 1ns/1ps

module cpu6502_alu
    ( input  cpu6502_arch_pkg::data_t a,
      input  cpu6502_arch_pkg::data_t b,
      input  logic                    c_in,
      input  logic [2:0]              op,      // ORA AND EOR ADC - - CMP SBC
      output cpu6502_arch_pkg::data_t result,
      output logic                    c_out,
      output logic                    v_out
      );

    wire logic sub   = op[2];           // CMP and SBC
    wire logic carry = c_in | ~op[0];   // CMP ignores C

    wire cpu6502_arch_pkg::data_t addend = sub ? ~b : b;
    wire logic [cpu6502_arch_pkg::data_width:0] sum =
        a + addend + cpu6502_arch_pkg::data_t'(carry);

    always_comb
    begin
        case (op)
            3'd0:    result = a | b;
            3'd1:    result = a & b;
            3'd2:    result = a ^ b;
            default: result = sum[cpu6502_arch_pkg::data_width-1:0];
        endcase
    end

    // Signed overflow from operand and result signs
    assign v_out = (a[7] ^ result[7]) & (addend[7] ^ result[7]);
    assign c_out = sum[cpu6502_arch_pkg::data_width];

endmodule

/* design/cpu6502_regs.sv */
`timescale 1ns/1ps

module cpu6502_regs
    ( input  logic                     clock,
      input  logic                     enable,
      input  cpu6502_arch_pkg::data_t  data_in,     // Registered memory byte
      input  cpu6502_isa_pkg::opcode_t opcode,
      input  cpu6502_arch_pkg::data_t  alu_result,
      input  logic                     alu_c,
      input  logic                     alu_v,
      input  logic db_data, db_alu, db_a, db_count,
      input  logic count_x, count_y, count_inc, count_dec,
      input  logic load_a, load_x, load_y,
      input  logic flag_nz, flag_c_alu, flag_v_alu, flag_c_ir, flag_v_ir,
      output cpu6502_arch_pkg::data_t  a,
      output cpu6502_arch_pkg::data_t  x,
      output cpu6502_arch_pkg::data_t  y,
      output cpu6502_arch_pkg::data_t  status,
      output logic                     flag_c
      );

    logic flag_n, flag_v, flag_z;

    // Counter unit, pass-through when neither inc nor dec
    wire cpu6502_arch_pkg::data_t count_in =
        ({cpu6502_arch_pkg::data_width{count_x}} & x) |
        ({cpu6502_arch_pkg::data_width{count_y}} & y);
    wire cpu6502_arch_pkg::data_t count_out =
        count_in + {cpu6502_arch_pkg::data_width{count_dec}} +
        cpu6502_arch_pkg::data_t'(count_inc);

    // Internal data bus, one source at a time
    wire cpu6502_arch_pkg::data_t db =
        ({cpu6502_arch_pkg::data_width{db_data}}  & data_in)    |
        ({cpu6502_arch_pkg::data_width{db_alu}}   & alu_result) |
        ({cpu6502_arch_pkg::data_width{db_a}}     & a)          |
        ({cpu6502_arch_pkg::data_width{db_count}} & count_out);

    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            if (load_a)
                a <= db;
            if (load_x)
                x <= db;
            if (load_y)
                y <= db;

            if (flag_nz)
            begin
                flag_n <= db[cpu6502_arch_pkg::data_width-1];
                flag_z <= db == '0;
            end

            // CLC and SEC differ only in bit 5
            if (flag_c_ir)
                flag_c <= opcode.raw[5];
            else if (flag_c_alu)
                flag_c <= alu_c;

            if (flag_v_ir)
                flag_v <= 1'b0;    // CLV
            else if (flag_v_alu)
                flag_v <= alu_v;
        end
    end

    always_comb
    begin
        status = '0;
        status[cpu6502_arch_pkg::status_n] = flag_n;
        status[cpu6502_arch_pkg::status_v] = flag_v;
        status[5]                          = 1'b1;  // Unused bit reads as one
        status[cpu6502_arch_pkg::status_z] = flag_z;
        status[cpu6502_arch_pkg::status_c] = flag_c;
    end

endmodule

/* design/cpu6502_bus.sv */
`timescale 1ns/1ps

module cpu6502_bus
    ( input  logic                     clock,
      input  logic                     reset,
      input  logic                     enable,
      input  cpu6502_arch_pkg::data_t  mem_data,
      input  cpu6502_arch_pkg::data_t  a,
      input  cpu6502_arch_pkg::data_t  x,
      input  cpu6502_arch_pkg::data_t  y,
      input  cpu6502_isa_pkg::opcode_t opcode,
      input  logic pc_inc, pc_vector,
      input  logic addr_pc, addr_zero, addr_hold,
      input  logic write_enable,
      input  logic [1:0] store_sel,
      output cpu6502_arch_pkg::addr_t  address,
      output cpu6502_arch_pkg::data_t  data_out,
      output cpu6502_arch_pkg::data_t  data_in,   // Byte from the previous cycle
      output cpu6502_arch_pkg::addr_t  pc
      );

    localparam int page_bits = cpu6502_arch_pkg::addr_width - cpu6502_arch_pkg::data_width;

    cpu6502_arch_pkg::addr_t last_addr;

    // STX is class x, STY the class below
    wire cpu6502_arch_pkg::data_t store_index =
        (opcode.fields.op_class == cpu6502_isa_pkg::class_x) ? x : y;

    assign address =
        ({cpu6502_arch_pkg::addr_width{addr_pc}}   & pc)                      |
        ({cpu6502_arch_pkg::addr_width{addr_zero}} & {{page_bits{1'b0}}, data_in}) |
        ({cpu6502_arch_pkg::addr_width{addr_hold}} & last_addr);

    assign data_out =
        ({cpu6502_arch_pkg::data_width{store_sel[0]}} & a) |
        ({cpu6502_arch_pkg::data_width{store_sel[1]}} & store_index);

    always_ff @(posedge clock)
    begin
        if (reset)
            pc <= cpu6502_arch_pkg::reset_vector;
        else if (enable)
        begin
            if (pc_vector)
                pc <= {mem_data, data_in};   // High byte live, low byte registered
            else
                pc <= pc + cpu6502_arch_pkg::addr_t'(pc_inc);
        end
    end

    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            last_addr <= address;
            // After a write the bus byte is the one written
            data_in <= write_enable ? data_out : mem_data;
        end
    end

endmodule

/* design/cpu6502_control.sv */
`timescale 1ns/1ps

module cpu6502_control
    ( input  logic                     clock,
      input  logic                     reset,
      input  logic                     enable,
      input  cpu6502_arch_pkg::data_t  mem_data,   // Opcode byte during fetch
      output cpu6502_isa_pkg::opcode_t opcode,
      output logic                     sync,
      output logic [2:0]               alu_op,
      output logic pc_inc, pc_vector,
      output logic addr_pc, addr_zero, addr_hold,
      output logic write_enable,
      output logic db_data, db_alu, db_a, db_count,
      output logic count_x, count_y, count_inc, count_dec,
      output logic load_a, load_x, load_y,
      output logic flag_nz, flag_c_alu, flag_v_alu, flag_c_ir, flag_v_ir,
      output logic [1:0] store_sel                 // Bit 0 stores A, bit 1 an index reg
      );

    cpu6502_isa_pkg::cycle_t state, next_state;

    // Field view
    wire logic [2:0] group    = opcode.fields.group;
    wire logic       class_a  = opcode.fields.op_class == cpu6502_isa_pkg::class_alu;
    wire logic       class_x  = opcode.fields.op_class == cpu6502_isa_pkg::class_x;
    wire logic       op_zp    = opcode.fields.mode == cpu6502_isa_pkg::mode_zeropage;
    wire logic       op_abs   = opcode.fields.mode == cpu6502_isa_pkg::mode_absolute; // JMP
    wire logic       op_imm   =
        (class_a & (opcode.fields.mode == cpu6502_isa_pkg::mode_immediate)) |
        (opcode.raw == cpu6502_isa_pkg::opcode_ldx_imm) |
        (opcode.raw == cpu6502_isa_pkg::opcode_ldy_imm);
    wire logic op_one_byte = ~op_imm & ~op_zp & ~op_abs;  // Implied and transfers

    wire logic op_store   = op_zp & (group == cpu6502_isa_pkg::group_store);
    wire logic op_load    = ~op_one_byte & (group == cpu6502_isa_pkg::group_load);
    wire logic op_arith   = class_a & ~op_one_byte & ~op_store & ~op_load;
    wire logic op_cmp     = op_arith & (group == cpu6502_isa_pkg::group_cmp);
    wire logic op_adc_sbc = op_arith & (group[1:0] == 2'b11);
    wire logic op_lda     = op_load & class_a;
    wire logic op_ldx     = op_load & class_x;
    wire logic op_ldy     = op_load & ~class_a & ~class_x;

    // Raw view
    wire logic op_tax = opcode.raw == cpu6502_isa_pkg::opcode_tax;
    wire logic op_tay = opcode.raw == cpu6502_isa_pkg::opcode_tay;
    wire logic op_txa = opcode.raw == cpu6502_isa_pkg::opcode_txa;
    wire logic op_tya = opcode.raw == cpu6502_isa_pkg::opcode_tya;
    wire logic op_inx = opcode.raw == cpu6502_isa_pkg::opcode_inx;
    wire logic op_iny = opcode.raw == cpu6502_isa_pkg::opcode_iny;
    wire logic op_dex = opcode.raw == cpu6502_isa_pkg::opcode_dex;
    wire logic op_dey = opcode.raw == cpu6502_isa_pkg::opcode_dey;
    wire logic op_clc_sec = (opcode.raw == cpu6502_isa_pkg::opcode_clc) |
                            (opcode.raw == cpu6502_isa_pkg::opcode_sec);
    wire logic op_clv = opcode.raw == cpu6502_isa_pkg::opcode_clv;

    wire logic update_a = op_lda | (op_arith & ~op_cmp) | op_txa | op_tya;
    wire logic update_x = op_ldx | op_tax | op_inx | op_dex;
    wire logic update_y = op_ldy | op_tay | op_iny | op_dey;
    wire logic wb       = state.byte1;  // Write-back slot of the previous instruction

    // Register and flag updates, overlapped with the next fetch
    assign db_data    = wb & op_load;
    assign db_alu     = wb & op_arith;
    assign db_a       = wb & (op_tax | op_tay);
    assign db_count   = wb & (op_txa | op_tya | op_inx | op_iny | op_dex | op_dey);
    assign count_x    = wb & (op_txa | op_inx | op_dex);
    assign count_y    = wb & (op_tya | op_iny | op_dey);
    assign count_inc  = wb & (op_inx | op_iny);
    assign count_dec  = wb & (op_dex | op_dey);
    assign load_a     = wb & update_a;
    assign load_x     = wb & update_x;
    assign load_y     = wb & update_y;
    assign flag_nz    = wb & (update_a | update_x | update_y | op_cmp);
    assign flag_c_alu = wb & (op_adc_sbc | op_cmp);
    assign flag_v_alu = wb & op_adc_sbc;
    assign flag_c_ir  = wb & op_clc_sec;
    assign flag_v_ir  = wb & op_clv;

    assign alu_op = group;
    assign sync   = state.byte1;

    always_comb
    begin
        next_state   = '0;
        pc_inc       = 1'b0;
        pc_vector    = 1'b0;
        addr_pc      = 1'b0;
        addr_zero    = 1'b0;
        addr_hold    = 1'b0;
        write_enable = 1'b0;
        store_sel    = 2'b00;

        if (state.byte1)
        begin
            addr_pc          = 1'b1;  // Fetch opcode
            pc_inc           = 1'b1;
            next_state.byte2 = 1'b1;
        end

        if (state.byte2)
        begin
            addr_pc             = ~op_one_byte;
            addr_hold           = op_one_byte;   // Dummy read at the opcode address
            pc_inc              = ~op_one_byte;
            next_state.byte1    = op_imm | op_one_byte;
            next_state.zeropage = op_zp;
            next_state.byte3    = op_abs;
        end

        if (state.byte3)
        begin
            // High byte on the bus, low byte already registered
            addr_pc          = 1'b1;
            pc_vector        = 1'b1;
            next_state.byte1 = 1'b1;
        end

        if (state.zeropage)
        begin
            addr_zero        = 1'b1;
            write_enable     = op_store;
            store_sel        = {op_store & ~class_a, op_store & class_a};
            next_state.byte1 = 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state      <= '{byte2: 1'b1, default: 1'b0};  // Enter JMP at the vector
            opcode.raw <= cpu6502_isa_pkg::opcode_jmp_abs;
        end
        else if (enable)
        begin
            state <= next_state;
            if (state.byte1)
                opcode.raw <= mem_data;
        end
    end

endmodule

/* design/cpu6502.sv */
`timescale 1ns/1ps

module cpu6502
    ( input  logic                    clock,
      input  logic                    reset,
      input  logic                    enable,        // Low level stalls the core
      input  cpu6502_arch_pkg::data_t data_in,       // Read data for current address
      output cpu6502_arch_pkg::addr_t address,
      output cpu6502_arch_pkg::data_t data_out,
      output logic                    write_enable,
      output logic                    sync,          // Opcode fetch cycle
      output cpu6502_arch_pkg::data_t debug_opcode,
      output cpu6502_arch_pkg::data_t debug_a,
      output cpu6502_arch_pkg::data_t debug_x,
      output cpu6502_arch_pkg::data_t debug_y,
      output cpu6502_arch_pkg::data_t debug_status,
      output cpu6502_arch_pkg::addr_t debug_pc
      );

    cpu6502_isa_pkg::opcode_t opcode;
    cpu6502_arch_pkg::data_t  bus_data;  // Registered byte from the bus unit
    cpu6502_arch_pkg::data_t  reg_a, reg_x, reg_y;
    cpu6502_arch_pkg::data_t  alu_result;
    logic [2:0] alu_op;
    logic [1:0] store_sel;
    logic alu_c, alu_v, flag_c;
    logic pc_inc, pc_vector, addr_pc, addr_zero, addr_hold;
    logic db_data, db_alu, db_a, db_count;
    logic count_x, count_y, count_inc, count_dec;
    logic load_a, load_x, load_y;
    logic flag_nz, flag_c_alu, flag_v_alu, flag_c_ir, flag_v_ir;

    cpu6502_control u_control
        ( .clock, .reset, .enable,
          .mem_data(data_in),
          .opcode, .sync, .alu_op,
          .pc_inc, .pc_vector, .addr_pc, .addr_zero, .addr_hold, .write_enable,
          .db_data, .db_alu, .db_a, .db_count,
          .count_x, .count_y, .count_inc, .count_dec,
          .load_a, .load_x, .load_y,
          .flag_nz, .flag_c_alu, .flag_v_alu, .flag_c_ir, .flag_v_ir,
          .store_sel );

    cpu6502_regs u_regs
        ( .clock, .enable,
          .data_in(bus_data), .opcode, .alu_result, .alu_c, .alu_v,
          .db_data, .db_alu, .db_a, .db_count,
          .count_x, .count_y, .count_inc, .count_dec,
          .load_a, .load_x, .load_y,
          .flag_nz, .flag_c_alu, .flag_v_alu, .flag_c_ir, .flag_v_ir,
          .a(reg_a), .x(reg_x), .y(reg_y), .status(debug_status), .flag_c );

    // A against the registered memory byte
    cpu6502_alu u_alu
        ( .a(reg_a), .b(bus_data), .c_in(flag_c), .op(alu_op),
          .result(alu_result), .c_out(alu_c), .v_out(alu_v) );

    cpu6502_bus u_bus
        ( .clock, .reset, .enable,
          .mem_data(data_in), .a(reg_a), .x(reg_x), .y(reg_y), .opcode,
          .pc_inc, .pc_vector, .addr_pc, .addr_zero, .addr_hold, .write_enable,
          .store_sel, .address, .data_out, .data_in(bus_data), .pc(debug_pc) );

    assign debug_opcode = opcode.raw;
    assign debug_a      = reg_a;
    assign debug_x      = reg_x;
    assign debug_y      = reg_y;

endmodule

/* verif/cpu6502_chk.sv */
`timescale 1ns/1ps

module cpu6502_chk
    ( input logic                    clock,
      input logic                    reset,
      input logic                    write_enable,
      input logic                    sync,
      input cpu6502_arch_pkg::addr_t address,
      input cpu6502_arch_pkg::addr_t debug_pc
      );

    int unsigned since_reset;     // Cycles since reset release
    logic        sync_seen;
    int unsigned fail_count = 0;  // Count of failed assertions

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            since_reset <= 0;
            sync_seen   <= 1'b0;
        end
        else
        begin
            since_reset <= since_reset + 1;
            sync_seen   <= sync_seen | sync;
        end
    end

    // A write cycle is never a fetch
    assert property (@(posedge clock) disable iff (reset) !(write_enable && sync))
    else
    begin
        fail_count++;
        $error("write_enable and sync high in the same cycle");
    end

    assert property (@(posedge clock) disable iff (reset) sync |-> address == debug_pc)
    else
    begin
        fail_count++;
        $error("Fetch address %h differs from program counter %h", address, debug_pc);
    end

    // Vector start-up is short
    assert property (@(posedge clock) disable iff (reset)
                     sync_seen || sync || since_reset < 4)
    else
    begin
        fail_count++;
        $error("No opcode fetch within 4 cycles of reset release");
    end

endmodule

/* verif/tb_cpu6502.sv */
`timescale 1ns/1ps

module tb_cpu6502;

    localparam int num_instr   = 60;
    localparam int cycle_limit = (num_instr * 3 + 20) * 5;  // 20 cycle margin and 5x stall allowance
    localparam int stall_from  = 30;                       // Enable held high before this

    // Opcodes with an operand byte come first and implied ones start at index 21
    localparam cpu6502_arch_pkg::data_t op_table [32] = '{
        8'h09, 8'h29, 8'h49, 8'h69, 8'hc9, 8'he9, 8'ha9, 8'ha2, 8'ha0,
        8'h05, 8'h25, 8'h45, 8'h65, 8'hc5, 8'he5, 8'ha5, 8'ha6, 8'ha4,
        8'h85, 8'h86, 8'h84,
        8'haa, 8'ha8, 8'h8a, 8'h98, 8'he8, 8'hc8, 8'hca, 8'h88, 8'h18, 8'h38, 8'hb8 };

    logic clock;
    logic reset;
    logic enable;
    logic write_enable;
    logic sync;
    cpu6502_arch_pkg::data_t mem_rdata, data_out;
    cpu6502_arch_pkg::data_t debug_opcode, debug_a, debug_x, debug_y, debug_status;
    cpu6502_arch_pkg::addr_t address, debug_pc;

    cpu6502_arch_pkg::data_t mem     [0:65535];  // Memory seen by the DUT
    cpu6502_arch_pkg::data_t ref_mem [0:65535];  // Model copy

    // Reference model state
    cpu6502_arch_pkg::data_t ref_a, ref_x, ref_y;
    logic ref_n, ref_v, ref_z, ref_c;
    cpu6502_arch_pkg::addr_t ref_pc, end_addr;
    cpu6502_arch_pkg::data_t ref_op;              // Opcode of the last modeled instruction
    int ref_cycles;                               // Cycle count of the last modeled instruction
    logic st_pending;                             // Store still owed by the DUT
    cpu6502_arch_pkg::data_t st_addr, st_data;
    cpu6502_arch_pkg::data_t snap_a, snap_x, snap_y, snap_status;

    logic [31:0] lfsr;
    int instr_count, cycle_gap, cycle_count;
    int value_errors, other_errors;
    logic end_seen, run_done;

    cpu6502 u_cpu6502
        ( .clock, .reset, .enable,
          .data_in(mem_rdata), .address, .data_out, .write_enable, .sync,
          .debug_opcode, .debug_a, .debug_x, .debug_y, .debug_status, .debug_pc );

    bind cpu6502 cpu6502_chk u_chk
        ( .clock, .reset, .write_enable, .sync, .address, .debug_pc );

    assign mem_rdata = mem[address];  // Combinational read

    always @(posedge clock)
    begin
        if (enable && write_enable)
            mem[address] <= data_out;
    end

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic cpu6502_arch_pkg::data_t rand_bits(input int n);
        cpu6502_arch_pkg::data_t value;
        int k;
        value = '0;
        for (k = 0; k < n; k++)
        begin
            lfsr  = lfsr_step(lfsr);
            value = {value[6:0], lfsr[0]};  // One step per bit
        end
        return value;
    endfunction

    task automatic emit(inout cpu6502_arch_pkg::addr_t pc, input cpu6502_arch_pkg::data_t value);
        ref_mem[pc] = value;
        pc          = pc + 16'd1;
    endtask

    // Fill pattern and then random zero page, vector and program at 0200
    task automatic load_memory();
        cpu6502_arch_pkg::addr_t pc;
        cpu6502_arch_pkg::addr_t target;
        cpu6502_arch_pkg::data_t pick;
        int skip;
        int i;
        for (i = 0; i < 65536; i++)
            ref_mem[i] = i[15:8] ^ {i[6:0], i[7]};
        for (i = 0; i < 256; i++)
            ref_mem[i] = rand_bits(8);
        ref_mem[cpu6502_arch_pkg::reset_vector]         = 8'h00;
        ref_mem[cpu6502_arch_pkg::reset_vector + 16'd1] = 8'h02;
        pc = 16'h0200;
        emit(pc, 8'ha9);                     // Prologue sets A X Y N Z C V
        emit(pc, rand_bits(8));
        emit(pc, 8'ha2);
        emit(pc, rand_bits(8));
        emit(pc, 8'ha0);
        emit(pc, rand_bits(8));
        emit(pc, 8'h18);
        emit(pc, 8'hb8);
        for (i = 5; i < num_instr - 1; i++)
        begin
            if (rand_bits(4) == 8'h00)
            begin
                skip   = int'(rand_bits(2));
                target = pc + 16'd3 + 16'(skip);
                emit(pc, 8'h4c);             // Forward JMP over junk bytes
                emit(pc, target[7:0]);
                emit(pc, target[15:8]);
                repeat (skip) emit(pc, rand_bits(8));
            end
            else
            begin
                pick = rand_bits(5);
                emit(pc, op_table[pick[4:0]]);
                if (pick < 8'd21)
                    emit(pc, rand_bits(8));
            end
        end
        end_addr = pc;
        emit(pc, 8'h4c);                     // Park on JMP to itself
        emit(pc, end_addr[7:0]);
        emit(pc, end_addr[15:8]);
        for (i = 0; i < 65536; i++)
            mem[i] <= ref_mem[i];
    endtask

    function automatic cpu6502_arch_pkg::data_t set_nz(input cpu6502_arch_pkg::data_t value);
        ref_n = value[7];
        ref_z = value == 8'h00;
        return value;
    endfunction

    function automatic void store_ref(input cpu6502_arch_pkg::data_t zp_addr,
                                      input cpu6502_arch_pkg::data_t value);
        ref_mem[{8'h00, zp_addr}] = value;
        st_addr    = zp_addr;
        st_data    = value;
        st_pending = 1'b1;
    endfunction

    // Executes the instruction at ref_pc on the model
    function automatic void execute_ref();
        cpu6502_arch_pkg::data_t op;
        cpu6502_arch_pkg::data_t arg;
        cpu6502_arch_pkg::data_t m;
        logic [8:0] sum;
        logic zp;
        cpu6502_arch_pkg::addr_t next_pc;
        op  = ref_mem[ref_pc];
        arg = ref_mem[ref_pc + 16'd1];
        zp  = op[3:0] inside {4'h4, 4'h5, 4'h6};      // Zero-page column
        m   = zp ? ref_mem[{8'h00, arg}] : arg;
        ref_op     = op;
        ref_cycles = zp ? 3 : 2;
        next_pc = ref_pc + ((op[3:0] == 4'h8 || op[3:0] == 4'ha) ? 16'd1 : 16'd2);
        case (op)
            8'h09, 8'h05: ref_a = set_nz(ref_a | m);
            8'h29, 8'h25: ref_a = set_nz(ref_a & m);
            8'h49, 8'h45: ref_a = set_nz(ref_a ^ m);
            8'h69, 8'h65:
            begin
                sum   = {1'b0, ref_a} + {1'b0, m} + {8'h00, ref_c};
                ref_v = (ref_a[7] == m[7]) && (sum[7] != ref_a[7]);
                ref_c = sum[8];
                ref_a = set_nz(sum[7:0]);
            end
            8'he9, 8'he5:
            begin
                sum   = {1'b0, ref_a} - {1'b0, m} - {8'h00, ~ref_c};
                ref_v = (ref_a[7] != m[7]) && (sum[7] != ref_a[7]);
                ref_c = ~sum[8];                        // Set when no borrow
                ref_a = set_nz(sum[7:0]);
            end
            8'hc9, 8'hc5:
            begin
                ref_c = ref_a >= m;
                void'(set_nz(ref_a - m));
            end
            8'ha9, 8'ha5: ref_a = set_nz(m);
            8'ha2, 8'ha6: ref_x = set_nz(m);
            8'ha0, 8'ha4: ref_y = set_nz(m);
            8'h85: store_ref(arg, ref_a);
            8'h86: store_ref(arg, ref_x);
            8'h84: store_ref(arg, ref_y);
            8'haa: ref_x = set_nz(ref_a);
            8'ha8: ref_y = set_nz(ref_a);
            8'h8a: ref_a = set_nz(ref_x);
            8'h98: ref_a = set_nz(ref_y);
            8'he8: ref_x = set_nz(ref_x + 8'd1);
            8'hc8: ref_y = set_nz(ref_y + 8'd1);
            8'hca: ref_x = set_nz(ref_x - 8'd1);
            8'h88: ref_y = set_nz(ref_y - 8'd1);
            8'h18: ref_c = 1'b0;
            8'h38: ref_c = 1'b1;
            8'hb8: ref_v = 1'b0;
            8'h4c:
            begin
                next_pc    = {ref_mem[ref_pc + 16'd2], arg};
                ref_cycles = 3;
            end
            default:
            begin
                $display("Model met opcode %h outside the subset at %h", op, ref_pc);
                other_errors++;
            end
        endcase
        ref_pc = next_pc;
    endfunction

    task automatic check_byte(input string name, input cpu6502_arch_pkg::data_t got,
                              input cpu6502_arch_pkg::data_t expected);
        if (got !== expected)
        begin
            $display("Error: %s is %h, expected %h", name, got, expected);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string name, input cpu6502_arch_pkg::addr_t got,
                              input cpu6502_arch_pkg::addr_t expected);
        if (got !== expected)
        begin
            $display("Error: %s is %h, expected %h", name, got, expected);
            value_errors++;
        end
    endtask

    task automatic check_status(input string name, input cpu6502_arch_pkg::data_t got,
                                input cpu6502_arch_pkg::data_t expected);
        if (got !== expected)
        begin
            $display("Error: %s is %h, expected %h (bits NV1000ZC)", name, got, expected);
            value_errors++;
        end
    endtask

    // Compare process that counts only enabled cycles
    always @(posedge clock)
    begin
        if (!reset && enable && !run_done)
        begin
            if (write_enable)
            begin
                if (!st_pending)
                begin
                    $display("Write cycle at address %h with no store pending", address);
                    other_errors++;
                end
                else
                begin
                    check_addr("address", address, {8'h00, st_addr});
                    check_byte("data_out", data_out, st_data);
                end
                st_pending = 1'b0;
            end
            if (!sync)
                cycle_gap++;
            else
            begin
                if (instr_count >= 6)               // Results lag one sync
                begin
                    check_byte("debug_a", debug_a, snap_a);
                    check_byte("debug_x", debug_x, snap_x);
                    check_byte("debug_y", debug_y, snap_y);
                    check_status("debug_status", debug_status, snap_status);
                end
                check_addr("debug_pc", debug_pc, ref_pc);
                check_addr("address", address, ref_pc);
                check_byte("debug_opcode", debug_opcode, ref_op);
                if (cycle_gap != ref_cycles)
                begin
                    $display("Instruction before %h took %0d cycles instead of %0d",
                             ref_pc, cycle_gap, ref_cycles);
                    other_errors++;
                end
                if (st_pending)
                begin
                    $display("Store before %h never wrote memory", ref_pc);
                    other_errors++;
                    st_pending = 1'b0;
                end
                cycle_gap = 1;
                if (ref_pc == end_addr && end_seen)
                    run_done = 1'b1;                // Second fetch of the final JMP
                else
                begin
                    end_seen    = end_seen | (ref_pc == end_addr);
                    snap_a      = ref_a;
                    snap_x      = ref_x;
                    snap_y      = ref_y;
                    snap_status = {ref_n, ref_v, 1'b1, 3'b000, ref_z, ref_c};
                    execute_ref();
                    instr_count++;
                end
            end
        end
    end

    // Random stalls in the second half
    always @(negedge clock)
    begin
        if (!reset && instr_count >= stall_from)
            enable = rand_bits(2) != 8'h00;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < cycle_limit)
        begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the program never reached its final JMP", cycle_limit);
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        int addr;
        reset        = 1'b1;
        enable       = 1'b1;
        lfsr         = 32'h390694a7;
        ref_pc       = 16'h0200;
        ref_op       = 8'h4c;                       // JMP forced in at reset
        ref_cycles   = 2;                           // Vector fetch before the first sync
        cycle_gap    = 0;
        instr_count  = 0;
        st_pending   = 1'b0;
        end_seen     = 1'b0;
        run_done     = 1'b0;
        value_errors = 0;
        other_errors = 0;
        load_memory();
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        wait (run_done);
        for (addr = 0; addr < 256; addr++)
            check_byte($sformatf("mem[%h]", addr), mem[addr], ref_mem[addr]);
        $display("Errors: %0d wrong values, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, u_cpu6502.u_chk.fail_count);
        if (value_errors == 0 && other_errors == 0 && u_cpu6502.u_chk.fail_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* all.f */
design/cpu6502_arch_pkg.sv
design/cpu6502_isa_pkg.sv
design/cpu6502_alu.sv
design/cpu6502_regs.sv
design/cpu6502_bus.sv
design/cpu6502_control.sv
design/cpu6502.sv
verif/cpu6502_chk.sv
verif/tb_cpu6502.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu6502 -f all.f -o sim_cpu6502
	./obj_dir/sim_cpu6502 | tee sim.log
	grep -qx "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
